// File: design/demux_pkg.sv
// stream demux shared definitions
// widths, channel map, packet type codes and the head word layouts

package demux_pkg;

   localparam int DATA_W = 64;             // stream word width
   localparam int N_CHAN = 4;              // output channels
   localparam int CHAN_W = 2;              // channel index width
   localparam int CNT_W  = 16;             // per-channel packet counter width

   // one bit per channel, a clear bit means nothing is connected there
   localparam logic [N_CHAN-1:0] ACTIVE_CHAN = 4'b1011;

   localparam logic [3:0] TYPE_DATA = 4'd1;   // stream data packet
   localparam logic [3:0] TYPE_CMD  = 4'd10;  // command packet

   localparam logic [CHAN_W-1:0] DEFAULT_CHAN = 2'd3;  // unknown types land here

   // data packet head word
   typedef struct packed {
      logic [3:0]  pkt_type;
      logic [11:0] rsvd;
      logic [15:0] pkt_size;   // words in packet, not checked
      logic [31:0] stream_id;  // low bits pick the channel
   } stream_hdr_t;

   // command packet head word
   typedef struct packed {
      logic [3:0]  pkt_type;
      logic [57:0] rsvd;
      logic [1:0]  dest_port;  // channel number directly
   } cmd_hdr_t;

   // the same 64 bits seen either way, type nibble sits on top in both
   typedef union packed {
      stream_hdr_t strm;
      cmd_hdr_t    cmd;
   } hdr_word_u;

endpackage

// File: design/flop_fifo2.sv
// two-entry register buffer for one stream word plus last
// ready toward the sender comes straight from a flop, throughput is one word per cycle

`timescale 1ns/100ps

module flop_fifo2
(
   input  logic                         clk,
   input  logic                         i_rst,
   input  logic                         i_clear,
   input  logic [demux_pkg::DATA_W-1:0] i_tdata,
   input  logic                         i_tlast,
   input  logic                         i_tvalid,
   output logic                         o_tready,
   output logic [demux_pkg::DATA_W-1:0] o_tdata,
   output logic                         o_tlast,
   output logic                         o_tvalid,
   input  logic                         i_tready
);

   logic [demux_pkg::DATA_W:0] head_q;  // {last, data} at the output
   logic [demux_pkg::DATA_W:0] spare_q; // second slot, only used under stall
   logic                       head_v;
   logic                       spare_v;
   logic                       push;
   logic                       pop;

   assign push = i_tvalid & o_tready;
   assign pop  = head_v & i_tready;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         head_v  <= 1'b0;
         spare_v <= 1'b0;
      end
      else
      begin
         if (pop)
         begin
            head_v  <= spare_v | push;
            spare_v <= 1'b0;  // a full buffer takes nothing in, so a pop frees the spare
         end
         else if (push)
         begin
            head_v  <= 1'b1;
            spare_v <= head_v;
         end
      end
   end

   // payload, no reset
   always_ff @(posedge clk)
   begin
      if (pop)
         head_q <= spare_v ? spare_q : {i_tlast, i_tdata};
      else if (push && !head_v)
         head_q <= {i_tlast, i_tdata};
      if (push && head_v && !pop)
         spare_q <= {i_tlast, i_tdata};
   end

   assign o_tready = ~spare_v;  // registered, full only with both slots taken
   assign o_tvalid = head_v;
   assign {o_tlast, o_tdata} = head_q;

endmodule

// File: design/header_router.sv
// header router
// reads the packet head word as either layout and picks the output channel

`timescale 1ns/100ps

module header_router
(
   input  logic [demux_pkg::DATA_W-1:0] i_head,
   output logic [demux_pkg::CHAN_W-1:0] o_dest
);

   demux_pkg::hdr_word_u hdr;

   assign hdr = i_head;

   // type nibble is shared by both views, decode it once
   always_comb
   begin
      case (hdr.strm.pkt_type)
         demux_pkg::TYPE_DATA, demux_pkg::TYPE_CMD:
         begin
            o_dest = hdr.cmd.dest_port;  // same two bits as the stream id low bits
         end
         default:
         begin
            o_dest = demux_pkg::DEFAULT_CHAN;
         end
      endcase
   end

endmodule

// File: design/demux_fsm.sv
// routing state machine for the stream demux
// latches a channel from the head word and holds it until the last word leaves,
// valid goes to that channel only and ready comes back from it

`timescale 1ns/100ps

module demux_fsm
(
   input  logic                         clk,
   input  logic                         i_rst,
   input  logic                         i_clear,
   input  logic                         i_tvalid,
   input  logic                         i_tlast,
   output logic                         o_tready,
   input  logic [demux_pkg::CHAN_W-1:0] i_dest,
   output logic [demux_pkg::N_CHAN-1:0] o_tvalid,
   input  logic [demux_pkg::N_CHAN-1:0] i_tready,
   output logic                         o_done,
   output logic [demux_pkg::CHAN_W-1:0] o_done_chan,
   output logic                         o_done_drop
);

   logic [demux_pkg::N_CHAN-1:0] state;  // one-hot channel, all zero is idle
   logic                         busy;
   logic                         xfer_last;

   assign busy      = |state;
   assign xfer_last = busy & i_tvalid & o_tready & i_tlast;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         state <= '0;
      end
      else if (!busy)
      begin
         if (i_tvalid)
            state <= {{(demux_pkg::N_CHAN-1){1'b0}}, 1'b1} << i_dest;
      end
      else if (xfer_last)
      begin
         state <= '0;  // one idle cycle before the next head is decoded
      end
   end

   // unconnected channels never see valid and always take words
   assign o_tvalid = state & {demux_pkg::N_CHAN{i_tvalid}} & demux_pkg::ACTIVE_CHAN;
   assign o_tready = |(state & (i_tready | ~demux_pkg::ACTIVE_CHAN));

   // one-hot to index for the counter
   always_comb
   begin
      o_done_chan = '0;
      for (int i = 0; i < demux_pkg::N_CHAN; i++)
      begin
         if (state[i])
            o_done_chan = i[demux_pkg::CHAN_W-1:0];
      end
   end

   assign o_done      = xfer_last;
   assign o_done_drop = |(state & ~demux_pkg::ACTIVE_CHAN);

endmodule

// File: design/pkt_counter.sv
// packet counters for the stream demux
// one saturating count per channel plus one for packets dropped on unconnected channels

`timescale 1ns/100ps

module pkt_counter
(
   input  logic                                           clk,
   input  logic                                           i_rst,
   input  logic                                           i_clear,
   input  logic                                           i_done,
   input  logic [demux_pkg::CHAN_W-1:0]                   i_done_chan,
   input  logic                                           i_done_drop,
   output logic [demux_pkg::N_CHAN*demux_pkg::CNT_W-1:0]  o_pkt_count,
   output logic [demux_pkg::CNT_W-1:0]                    o_drop_count
);

   logic [demux_pkg::CNT_W-1:0] chan_cnt [demux_pkg::N_CHAN];
   logic [demux_pkg::CNT_W-1:0] drop_cnt;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         for (int i = 0; i < demux_pkg::N_CHAN; i++)
            chan_cnt[i] <= '0;
         drop_cnt <= '0;
      end
      else if (i_done)
      begin
         if (i_done_drop)
         begin
            if (drop_cnt != '1)
               drop_cnt <= drop_cnt + 1'b1;
         end
         else if (chan_cnt[i_done_chan] != '1)  // hold at all ones
         begin
            chan_cnt[i_done_chan] <= chan_cnt[i_done_chan] + 1'b1;
         end
      end
   end

   for (genvar g = 0; g < demux_pkg::N_CHAN; g++)
   begin : g_flat
      assign o_pkt_count[g*demux_pkg::CNT_W +: demux_pkg::CNT_W] = chan_cnt[g];
   end

   assign o_drop_count = drop_cnt;

endmodule

// File: design/stream_demux_top.sv
// packet stream demux top level
// buffered 64-bit input, each packet steered whole to one of four channels,
// with per-channel and drop packet counters

`timescale 1ns/100ps

module stream_demux_top
(
   input  logic                                           clk,
   input  logic                                           i_rst,
   input  logic                                           i_clear,
   input  logic [demux_pkg::DATA_W-1:0]                   i_tdata,
   input  logic                                           i_tlast,
   input  logic                                           i_tvalid,
   output logic                                           o_tready,
   output logic [demux_pkg::DATA_W-1:0]                   o_tdata,
   output logic                                           o_tlast,
   output logic [demux_pkg::N_CHAN-1:0]                   o_tvalid,
   input  logic [demux_pkg::N_CHAN-1:0]                   i_tready,
   output logic [demux_pkg::N_CHAN*demux_pkg::CNT_W-1:0]  o_pkt_count,
   output logic [demux_pkg::CNT_W-1:0]                    o_drop_count
);

   logic                         head_valid;
   logic                         head_ready;
   logic [demux_pkg::CHAN_W-1:0] dest;
   logic                         done;
   logic [demux_pkg::CHAN_W-1:0] done_chan;
   logic                         done_drop;

   // head data and last fan out to every channel as is
   flop_fifo2 u_fifo (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_clear  (i_clear),
      .i_tdata  (i_tdata),
      .i_tlast  (i_tlast),
      .i_tvalid (i_tvalid),
      .o_tready (o_tready),
      .o_tdata  (o_tdata),
      .o_tlast  (o_tlast),
      .o_tvalid (head_valid),
      .i_tready (head_ready)
   );

   header_router u_router (
      .i_head (o_tdata),
      .o_dest (dest)     // only looked at while idle
   );

   demux_fsm u_fsm (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_clear     (i_clear),
      .i_tvalid    (head_valid),
      .i_tlast     (o_tlast),
      .o_tready    (head_ready),
      .i_dest      (dest),
      .o_tvalid    (o_tvalid),
      .i_tready    (i_tready),
      .o_done      (done),
      .o_done_chan (done_chan),
      .o_done_drop (done_drop)
   );

   pkt_counter u_counter (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_clear      (i_clear),
      .i_done       (done),
      .i_done_chan  (done_chan),
      .i_done_drop  (done_drop),
      .o_pkt_count  (o_pkt_count),
      .o_drop_count (o_drop_count)
   );

endmodule

// File: verification/stream_demux_chk.sv
// output protocol checker for the stream demux, bound into the top level
// one-hot valid, stall stability, unconnected channels silent, clean reset

`timescale 1ns/100ps

module stream_demux_chk
(
   input logic                         clk,
   input logic                         i_rst,
   input logic                         i_clear,
   input logic [demux_pkg::N_CHAN-1:0] o_tvalid,
   input logic [demux_pkg::N_CHAN-1:0] i_tready,
   input logic [demux_pkg::DATA_W-1:0] o_tdata,
   input logic                         o_tlast
);

   int fail_cnt = 0;  // summed into the testbench error count

   a_onehot: assert property (@(posedge clk) disable iff (i_rst) $onehot0(o_tvalid))
      else begin $error("more than one channel valid"); fail_cnt++; end

   // a stalled word keeps its channel, data and last
   a_stall: assert property (@(posedge clk) disable iff (i_rst || i_clear)
      |(o_tvalid & ~i_tready) |=>
         (o_tvalid == $past(o_tvalid)) && $stable(o_tdata) && $stable(o_tlast))
      else begin $error("output changed while stalled"); fail_cnt++; end

   a_inactive: assert property (@(posedge clk) disable iff (i_rst)
      (o_tvalid & ~demux_pkg::ACTIVE_CHAN) == '0)
      else begin $error("valid on an unconnected channel"); fail_cnt++; end

   a_reset: assert property (@(posedge clk) i_rst |=> o_tvalid == '0)
      else begin $error("valid high after reset"); fail_cnt++; end

endmodule

bind stream_demux_top stream_demux_chk u_chk
(
   .clk      (clk),
   .i_rst    (i_rst),
   .i_clear  (i_clear),
   .o_tvalid (o_tvalid),
   .i_tready (i_tready),
   .o_tdata  (o_tdata),
   .o_tlast  (o_tlast)
);

// File: verification/tb_stream_demux.sv
// testbench for the packet stream demux
// random packets against a queue model of the expected output, checked by assertions

`timescale 1ns/100ps

module tb_stream_demux;

   localparam int TIMEOUT = 300;  // cycles allowed per wait

   logic                                          clk;
   logic                                          i_rst;
   logic                                          i_clear;
   logic [demux_pkg::DATA_W-1:0]                  i_tdata;
   logic                                          i_tlast;
   logic                                          i_tvalid;
   logic                                          o_tready;
   logic [demux_pkg::DATA_W-1:0]                  o_tdata;
   logic                                          o_tlast;
   logic [demux_pkg::N_CHAN-1:0]                  o_tvalid;
   logic [demux_pkg::N_CHAN-1:0]                  i_tready = '1;
   logic [demux_pkg::N_CHAN*demux_pkg::CNT_W-1:0] o_pkt_count;
   logic [demux_pkg::CNT_W-1:0]                   o_drop_count;

   integer seed;
   int     errors = 0;
   int     checks = 0;
   int     mon_errors = 0;   // counted by the output monitor
   int     mon_checks = 0;
   int     mark = 0;
   int     ready_mode = 0;   // 0 all ready, 1 random, 2 none
   bit     stalled = 0;
   logic [demux_pkg::DATA_W+demux_pkg::CHAN_W:0] exp_q [$];  // {chan, last, data}
   logic [demux_pkg::CNT_W-1:0] exp_cnt [demux_pkg::N_CHAN] = '{default: '0};
   logic [demux_pkg::CNT_W-1:0] exp_drop = '0;

   stream_demux_top i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(negedge clk)
   begin
      case (ready_mode)
         0: i_tready = '1;
         1: i_tready = 4'($random(seed));
         default: i_tready = '0;
      endcase
   end

   // data packets use stream id bits [1:0], commands the port field, also bits [1:0]
   function automatic logic [1:0] expected_chan(input logic [63:0] head);
      if (head[63:60] == demux_pkg::TYPE_DATA || head[63:60] == demux_pkg::TYPE_CMD)
         return head[1:0];
      return 2'd3;
   endfunction

   function automatic bit counts_match();
      for (int c = 0; c < demux_pkg::N_CHAN; c++)
      begin
         if (o_pkt_count[c*demux_pkg::CNT_W +: demux_pkg::CNT_W] != exp_cnt[c])
            return 0;
      end
      return o_drop_count == exp_drop;
   endfunction

   function automatic int total_errors();
      return errors + mon_errors + i_dut.u_chk.fail_cnt;
   endfunction

   // every output transfer must be the next expected word on the right channel
   always @(posedge clk)
   begin
      logic [demux_pkg::DATA_W+demux_pkg::CHAN_W:0] exp_word;
      bit exp_ok;
      for (int c = 0; c < demux_pkg::N_CHAN; c++)
      begin
         if (!i_rst && o_tvalid[c] && i_tready[c])
         begin
            mon_checks++;
            exp_ok = exp_q.size() > 0;
            if (exp_ok)
               exp_word = exp_q.pop_front();
            assert (exp_ok && exp_word == {2'(c), o_tlast, o_tdata})
            else
            begin
               $display("mismatch at %0t: channel %0d data %h last %b, expected %h",
                        $time, c, o_tdata, o_tlast, exp_word);
               mon_errors++;
            end
         end
      end
   end

   task automatic wait_accept();
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!o_tready && n < TIMEOUT);
      if (!o_tready)
      begin
         $display("timeout at %0t: stream stalled, input word not accepted", $time);
         stalled = 1;
         errors++;
      end
   endtask

   // kind 0 data, 1 command, 2 unknown type; to_chan below zero leaves the channel random
   task automatic send_packet(input int kind, input int to_chan);
      demux_pkg::hdr_word_u hdr;
      logic [1:0]  chan;
      logic [63:0] word;
      int          len;
      hdr = {$random(seed), $random(seed)};
      len = 1 + $unsigned($random(seed)) % 6;
      if (kind == 0)
         hdr.strm.pkt_type = demux_pkg::TYPE_DATA;
      else if (kind == 1)
         hdr.cmd.pkt_type = demux_pkg::TYPE_CMD;
      else
         hdr.strm.pkt_type = 4'd2 + 4'($unsigned($random(seed)) % 8);  // never 1 or 10
      if (to_chan >= 0 && kind == 0)
         hdr.strm.stream_id[1:0] = 2'(to_chan);
      else if (to_chan >= 0)
         hdr.cmd.dest_port = 2'(to_chan);
      chan = expected_chan(hdr);
      for (int i = 0; i < len && !stalled; i++)
      begin
         word = (i == 0) ? hdr : {$random(seed), $random(seed)};
         i_tdata  = word;
         i_tlast  = (i == len - 1);
         i_tvalid = 1'b1;
         wait_accept();
         if (demux_pkg::ACTIVE_CHAN[chan])
            exp_q.push_back({chan, i_tlast, word});
         if (i_tlast && demux_pkg::ACTIVE_CHAN[chan])
            exp_cnt[chan] = exp_cnt[chan] + 1'b1;
         else if (i_tlast)
            exp_drop = exp_drop + 1'b1;
         @(negedge clk);
      end
      i_tvalid = 1'b0;
   endtask

   task automatic drain_and_check();
      int n;
      n = 0;
      if (stalled)
         return;
      while ((exp_q.size() != 0 || !counts_match()) && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout at %0t: stream stalled, %0d words never came out",
                  $time, exp_q.size());
         stalled = 1;
         errors++;
      end
      checks++;
      assert (counts_match())
      else
      begin
         $display("mismatch at %0t: counts %h drop %0d, expected drop %0d",
                  $time, o_pkt_count, o_drop_count, exp_drop);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("%s: done, %0d errors", name, total_errors() - mark);
      mark = total_errors();
   endtask

   initial
   begin
      seed     = 12;
      i_rst    = 1'b1;
      i_clear  = 1'b0;
      i_tdata  = '0;
      i_tlast  = 1'b0;
      i_tvalid = 1'b0;
      repeat (10) @(negedge clk);
      i_rst = 1'b0;
      checks++;
      assert (o_tvalid == '0 && o_tready && counts_match())
      else
      begin
         $display("mismatch at %0t: bad state after reset", $time);
         errors++;
      end
      end_test("reset state");

      // every type meets several channels, unknown types carry a port that must be ignored
      for (int k = 0; k < 9; k++)
         send_packet(k % 3, k % 4);
      drain_and_check();
      end_test("routing");

      ready_mode = 1;
      for (int k = 0; k < 20; k++)
         send_packet($unsigned($random(seed)) % 3, -1);
      drain_and_check();
      end_test("back-pressure");

      ready_mode = 2;  // nothing ready, channel 2 packets must still drain
      for (int k = 0; k < 4; k++)
         send_packet(k % 2, 2);
      drain_and_check();
      ready_mode = 0;
      end_test("inactive channel");

      @(negedge clk);
      i_clear = 1'b1;
      @(negedge clk);
      i_clear  = 1'b0;
      exp_cnt  = '{default: '0};
      exp_drop = '0;
      checks++;
      assert (o_tvalid == '0 && counts_match())
      else
      begin
         $display("mismatch at %0t: counters not zero after clear", $time);
         errors++;
      end
      send_packet(0, 1);
      drain_and_check();
      end_test("counters and clear");

      $display("5 tests, %0d checks, %0d errors", checks + mon_checks, total_errors());
      if (total_errors() == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: sim.f
design/demux_pkg.sv
design/flop_fifo2.sv
design/header_router.sv
design/demux_fsm.sv
design/pkt_counter.sv
design/stream_demux_top.sv
verification/stream_demux_chk.sv
verification/tb_stream_demux.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := sim.f
TOP        := tb_stream_demux
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
